//--- source/uart_axi_pkg.sv
package uart_axi_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [7:0]  byte_t;

	// register window
	localparam addr_t UART_BASE_ADDR = 32'h2000_0000;
	localparam addr_t UART_ADDR_MASK = 32'h0000_000F;

	// decoded from address bits 3:2
	typedef enum logic [1:0] {
		REG_CTRL   = 2'b00,
		REG_STATUS = 2'b01,
		REG_RDATA  = 2'b10,
		REG_WDATA  = 2'b11
	} reg_sel_t;

	// control register fields
	localparam int CTRL_TX_EN_BIT = 0;
	localparam int CTRL_RX_EN_BIT = 1;
	localparam int CTRL_BAUD_LSB  = 16;

	// status word bits
	localparam int STAT_RX_EMPTY = 3;
	localparam int STAT_RX_FULL  = 2;
	localparam int STAT_TX_EMPTY = 1;
	localparam int STAT_TX_FULL  = 0;

	localparam logic [3:0] STATUS_RESET = 4'hA; // both queues empty

endpackage

//--- source/uart_axi_fsm.sv
`timescale 1ns/1ps

module uart_axi_fsm (
	input  logic                     s_axi_aclk_i,
	input  logic                     s_axi_aresetn_i,
	input  uart_axi_pkg::addr_t      s_axi_araddr_i,
	input  logic                     s_axi_arvalid_i,
	output logic                     s_axi_arready_o,
	input  logic                     s_axi_rready_i,
	output logic                     s_axi_rvalid_o,
	output uart_axi_pkg::data_t      s_axi_rdata_o,
	output logic                     s_axi_rresp_o,
	input  uart_axi_pkg::addr_t      s_axi_awaddr_i,
	input  logic                     s_axi_awvalid_i,
	output logic                     s_axi_awready_o,
	input  uart_axi_pkg::data_t      s_axi_wdata_i,
	input  uart_axi_pkg::strb_t      s_axi_wstrb_i,
	input  logic                     s_axi_wvalid_i,
	output logic                     s_axi_wready_o,
	input  logic                     s_axi_bready_i,
	output logic                     s_axi_bvalid_o,
	output logic                     s_axi_bresp_o,
	input  uart_axi_pkg::data_t      rd_data_i,
	input  logic                     rd_ok_i,
	input  logic                     wr_ok_i,
	output logic                     rd_pulse_o,
	output logic                     wr_pulse_o,
	output uart_axi_pkg::reg_sel_t   rd_sel_o,
	output uart_axi_pkg::reg_sel_t   wr_sel_o,
	output uart_axi_pkg::data_t      wr_data_o,
	output uart_axi_pkg::strb_t      wr_strb_o
);

	logic                   rd_wait; // address taken, waiting for rready
	logic                   wr_wait;
	uart_axi_pkg::reg_sel_t ar_sel;
	uart_axi_pkg::reg_sel_t aw_sel;
	logic                   ar_hit;
	logic                   aw_hit;
	logic                   rd_accept;
	logic                   wr_accept;

	assign ar_sel = uart_axi_pkg::reg_sel_t'(s_axi_araddr_i[3:2]);
	assign aw_sel = uart_axi_pkg::reg_sel_t'(s_axi_awaddr_i[3:2]);

	assign ar_hit = (s_axi_araddr_i & ~uart_axi_pkg::UART_ADDR_MASK) == uart_axi_pkg::UART_BASE_ADDR;
	assign aw_hit = (s_axi_awaddr_i & ~uart_axi_pkg::UART_ADDR_MASK) == uart_axi_pkg::UART_BASE_ADDR;

	// transmit data is write only
	assign rd_accept = !rd_wait && s_axi_arvalid_i && ar_hit && (ar_sel != uart_axi_pkg::REG_WDATA);
	// only control and transmit data take writes
	assign wr_accept = !wr_wait && s_axi_awvalid_i && s_axi_wvalid_i && aw_hit &&
		((aw_sel == uart_axi_pkg::REG_CTRL) || (aw_sel == uart_axi_pkg::REG_WDATA));

	assign rd_pulse_o = rd_wait && s_axi_rready_i;
	assign wr_pulse_o = wr_wait && s_axi_bready_i;

	// read channel
	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			rd_wait         <= 1'b0;
			s_axi_arready_o <= 1'b0;
			s_axi_rvalid_o  <= 1'b0;
			s_axi_rresp_o   <= 1'b0;
		end else begin
			s_axi_arready_o <= rd_accept;
			s_axi_rvalid_o  <= rd_pulse_o;
			if (rd_accept)
				rd_wait <= 1'b1;
			else if (rd_pulse_o)
				rd_wait <= 1'b0;
			if (rd_pulse_o)
				s_axi_rresp_o <= rd_ok_i; // held until next read
		end
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (rd_accept)
			rd_sel_o <= ar_sel;
		if (rd_pulse_o)
			s_axi_rdata_o <= rd_data_i;
	end

	// write channel
	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			wr_wait         <= 1'b0;
			s_axi_awready_o <= 1'b0;
			s_axi_wready_o  <= 1'b0;
			s_axi_bvalid_o  <= 1'b0;
			s_axi_bresp_o   <= 1'b0;
		end else begin
			s_axi_awready_o <= wr_accept;
			s_axi_wready_o  <= wr_accept;
			s_axi_bvalid_o  <= wr_pulse_o;
			if (wr_accept)
				wr_wait <= 1'b1;
			else if (wr_pulse_o)
				wr_wait <= 1'b0;
			if (wr_pulse_o)
				s_axi_bresp_o <= wr_ok_i;
		end
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (wr_accept) begin
			wr_sel_o  <= aw_sel;
			wr_data_o <= s_axi_wdata_i;
			wr_strb_o <= s_axi_wstrb_i;
		end
	end

endmodule

//--- source/uart_reg_file.sv
`timescale 1ns/1ps

module uart_reg_file #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic                    s_axi_aclk_i,
	input  logic                    s_axi_aresetn_i,
	input  logic                    rd_pulse_i,
	input  logic                    wr_pulse_i,
	input  uart_axi_pkg::reg_sel_t  rd_sel_i,
	input  uart_axi_pkg::reg_sel_t  wr_sel_i,
	input  uart_axi_pkg::data_t     wr_data_i,
	input  uart_axi_pkg::strb_t     wr_strb_i,
	input  logic                    r_done_i,
	input  uart_axi_pkg::byte_t     rx_i,
	input  logic                    tx_full_i,
	input  logic                    tx_empty_i,
	input  logic                    rx_full_i,
	input  logic                    rx_empty_i,
	input  uart_axi_pkg::byte_t     rx_head_i,
	input  logic                    tx_drained_i,
	output uart_axi_pkg::data_t     rd_data_o,
	output logic                    rd_ok_o,
	output logic                    wr_ok_o,
	output logic                    tx_push_o,
	output uart_axi_pkg::byte_t     tx_byte_o,
	output logic                    rx_pop_o,
	output logic                    rx_push_o,
	output uart_axi_pkg::byte_t     rx_byte_o,
	output logic                    tx_en_o,
	output logic                    rx_en_o,
	output logic [15:0]             baud_div_o
);

	uart_axi_pkg::data_t ctrl;
	logic [3:0]          status;
	logic                ctrl_wr;
	logic                rx_fills;

	assign tx_en_o    = ctrl[uart_axi_pkg::CTRL_TX_EN_BIT];
	assign rx_en_o    = ctrl[uart_axi_pkg::CTRL_RX_EN_BIT];
	assign baud_div_o = ctrl[uart_axi_pkg::CTRL_BAUD_LSB +: 16];

	assign ctrl_wr   = wr_pulse_i && (wr_sel_i == uart_axi_pkg::REG_CTRL);
	assign tx_push_o = wr_pulse_i && (wr_sel_i == uart_axi_pkg::REG_WDATA) && !tx_full_i;
	assign tx_byte_o = wr_data_i[7:0];
	assign wr_ok_o   = (wr_sel_i == uart_axi_pkg::REG_WDATA) ? !tx_full_i : 1'b1;

	assign rx_pop_o  = rd_pulse_i && (rd_sel_i == uart_axi_pkg::REG_RDATA) && !rx_empty_i;
	assign rx_push_o = r_done_i && rx_en_o && !rx_full_i;
	assign rx_byte_o = rx_i;

	// a single-entry queue is full right after its push
	assign rx_fills = rx_full_i || (rx_push_o && (FIFO_DEPTH == 1));

	always_comb begin
		rd_data_o = '0;
		rd_ok_o   = 1'b1;
		case (rd_sel_i)
			uart_axi_pkg::REG_CTRL:   rd_data_o = ctrl;
			uart_axi_pkg::REG_STATUS: rd_data_o = uart_axi_pkg::data_t'(status);
			uart_axi_pkg::REG_RDATA: begin
				rd_ok_o = !rx_empty_i; // empty queue reads 0, refused
				if (!rx_empty_i)
					rd_data_o = uart_axi_pkg::data_t'(rx_head_i);
			end
			default: rd_ok_o = 1'b0;
		endcase
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			ctrl <= '0;
		end else begin
			if (ctrl_wr) begin
				for (int i = 0; i < 4; i++) begin
					if (wr_strb_i[i])
						ctrl[8*i +: 8] <= wr_data_i[8*i +: 8];
				end
			end
			// enables drop on their own, over any write
			if (tx_drained_i)
				ctrl[uart_axi_pkg::CTRL_TX_EN_BIT] <= 1'b0;
			if (rx_fills)
				ctrl[uart_axi_pkg::CTRL_RX_EN_BIT] <= 1'b0;
		end
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			status <= uart_axi_pkg::STATUS_RESET;
		end else begin
			status[uart_axi_pkg::STAT_RX_EMPTY] <= rx_empty_i;
			status[uart_axi_pkg::STAT_RX_FULL]  <= rx_full_i;
			status[uart_axi_pkg::STAT_TX_EMPTY] <= tx_empty_i;
			status[uart_axi_pkg::STAT_TX_FULL]  <= tx_full_i;
		end
	end

endmodule

//--- source/uart_byte_fifo.sv
`timescale 1ns/1ps

module uart_byte_fifo #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic                 s_axi_aclk_i,
	input  logic                 s_axi_aresetn_i,
	input  logic                 push_i,
	input  uart_axi_pkg::byte_t  push_byte_i,
	input  logic                 pop_i,
	output uart_axi_pkg::byte_t  head_o,
	output logic                 full_o,
	output logic                 empty_o
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(FIFO_DEPTH);

	uart_axi_pkg::byte_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic                do_push;
	logic                do_pop;

	assign full_o  = (count == DEPTH_CNT);
	assign empty_o = (count == '0);
	assign head_o  = mem[rd_ptr];

	assign do_push = push_i && !full_o; // dropped when full
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (FIFO_DEPTH > 1) ? wr_ptr + 1'b1 : '0; // wraps at power of two
			if (do_pop)
				rd_ptr <= (FIFO_DEPTH > 1) ? rd_ptr + 1'b1 : '0;
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (do_push)
			mem[wr_ptr] <= push_byte_i;
	end

endmodule

//--- source/uart_tx_feeder.sv
`timescale 1ns/1ps

module uart_tx_feeder (
	input  logic                 s_axi_aclk_i,
	input  logic                 s_axi_aresetn_i,
	input  logic                 tx_en_i,
	input  logic                 t_done_i,
	input  uart_axi_pkg::byte_t  head_i,
	input  logic                 empty_i,
	output uart_axi_pkg::byte_t  tx_o,
	output logic                 pop_o,
	output logic                 drained_o
);

	logic popped; // a pop went through last cycle

	assign pop_o = t_done_i && tx_en_i && !empty_i;

	// queue empty right after a pop, the last byte is gone
	assign drained_o = popped && empty_i;

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i)
			popped <= 1'b0;
		else
			popped <= pop_o;
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (tx_en_i && !empty_i)
			tx_o <= head_i; // keeps last byte otherwise
	end

endmodule

//--- source/uart_axi_regs.sv
`timescale 1ns/1ps

module uart_axi_regs #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic                 s_axi_aclk_i,
	input  logic                 s_axi_aresetn_i,
	input  uart_axi_pkg::addr_t  s_axi_araddr_i,
	input  logic                 s_axi_arvalid_i,
	output logic                 s_axi_arready_o,
	input  logic                 s_axi_rready_i,
	output logic                 s_axi_rvalid_o,
	output uart_axi_pkg::data_t  s_axi_rdata_o,
	output logic                 s_axi_rresp_o,
	input  uart_axi_pkg::addr_t  s_axi_awaddr_i,
	input  logic                 s_axi_awvalid_i,
	output logic                 s_axi_awready_o,
	input  uart_axi_pkg::data_t  s_axi_wdata_i,
	input  uart_axi_pkg::strb_t  s_axi_wstrb_i,
	input  logic                 s_axi_wvalid_i,
	output logic                 s_axi_wready_o,
	input  logic                 s_axi_bready_i,
	output logic                 s_axi_bvalid_o,
	output logic                 s_axi_bresp_o,
	input  logic                 r_done_i,
	input  logic                 t_done_i,
	input  uart_axi_pkg::byte_t  rx_i,
	output logic                 rx_en_o,
	output logic                 tx_en_o,
	output uart_axi_pkg::byte_t  tx_o,
	output logic [15:0]          baud_div_o
);

	logic                   rd_pulse;
	logic                   wr_pulse;
	uart_axi_pkg::reg_sel_t rd_sel;
	uart_axi_pkg::reg_sel_t wr_sel;
	uart_axi_pkg::data_t    wr_data;
	uart_axi_pkg::strb_t    wr_strb;
	uart_axi_pkg::data_t    rd_data;
	logic                   rd_ok;
	logic                   wr_ok;
	logic                   tx_push;
	logic                   tx_pop;
	uart_axi_pkg::byte_t    tx_byte;
	uart_axi_pkg::byte_t    tx_head;
	logic                   tx_full;
	logic                   tx_empty;
	logic                   tx_drained;
	logic                   rx_push;
	logic                   rx_pop;
	uart_axi_pkg::byte_t    rx_byte;
	uart_axi_pkg::byte_t    rx_head;
	logic                   rx_full;
	logic                   rx_empty;

	uart_axi_fsm fsm0 (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.s_axi_araddr_i, .s_axi_arvalid_i, .s_axi_arready_o,
		.s_axi_rready_i, .s_axi_rvalid_o, .s_axi_rdata_o, .s_axi_rresp_o,
		.s_axi_awaddr_i, .s_axi_awvalid_i, .s_axi_awready_o,
		.s_axi_wdata_i, .s_axi_wstrb_i, .s_axi_wvalid_i, .s_axi_wready_o,
		.s_axi_bready_i, .s_axi_bvalid_o, .s_axi_bresp_o,
		.rd_data_i(rd_data), .rd_ok_i(rd_ok), .wr_ok_i(wr_ok),
		.rd_pulse_o(rd_pulse), .wr_pulse_o(wr_pulse),
		.rd_sel_o(rd_sel), .wr_sel_o(wr_sel),
		.wr_data_o(wr_data), .wr_strb_o(wr_strb)
	);

	uart_reg_file #(.FIFO_DEPTH(FIFO_DEPTH)) regs0 (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.rd_pulse_i(rd_pulse), .wr_pulse_i(wr_pulse),
		.rd_sel_i(rd_sel), .wr_sel_i(wr_sel),
		.wr_data_i(wr_data), .wr_strb_i(wr_strb),
		.r_done_i, .rx_i,
		.tx_full_i(tx_full), .tx_empty_i(tx_empty),
		.rx_full_i(rx_full), .rx_empty_i(rx_empty), .rx_head_i(rx_head),
		.tx_drained_i(tx_drained),
		.rd_data_o(rd_data), .rd_ok_o(rd_ok), .wr_ok_o(wr_ok),
		.tx_push_o(tx_push), .tx_byte_o(tx_byte),
		.rx_pop_o(rx_pop), .rx_push_o(rx_push), .rx_byte_o(rx_byte),
		.tx_en_o, .rx_en_o, .baud_div_o
	);

	uart_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.push_i(tx_push), .push_byte_i(tx_byte), .pop_i(tx_pop),
		.head_o(tx_head), .full_o(tx_full), .empty_o(tx_empty)
	);

	uart_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.push_i(rx_push), .push_byte_i(rx_byte), .pop_i(rx_pop),
		.head_o(rx_head), .full_o(rx_full), .empty_o(rx_empty)
	);

	uart_tx_feeder feeder0 (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.tx_en_i(tx_en_o), .t_done_i,
		.head_i(tx_head), .empty_i(tx_empty),
		.tx_o, .pop_o(tx_pop), .drained_o(tx_drained)
	);

endmodule

//--- include/tb_uart_checks.svh
`ifndef TB_UART_CHECKS_SVH
`define TB_UART_CHECKS_SVH

localparam int WAIT_LIMIT = 1000; // cycles per wait loop

// reference state: control word and both byte queues
uart_axi_pkg::data_t m_ctrl = '0;
uart_axi_pkg::byte_t tx_q[$];
uart_axi_pkg::byte_t rx_q[$];
logic [31:0]         rng = 32'd3;

function logic [31:0] next_rand();
	rng = rng ^ (rng << 13);
	rng = rng ^ (rng >> 17);
	rng = rng ^ (rng << 5);
	return rng;
endfunction

// expected read data and response flag, pops the rx model on a data read
function automatic uart_axi_pkg::data_t model_read(input uart_axi_pkg::reg_sel_t sel,
		output logic ok);
	uart_axi_pkg::data_t d;
	d  = '0;
	ok = 1'b1;
	case (sel)
		uart_axi_pkg::REG_CTRL: d = m_ctrl;
		uart_axi_pkg::REG_STATUS: begin
			d[uart_axi_pkg::STAT_RX_EMPTY] = (rx_q.size() == 0);
			d[uart_axi_pkg::STAT_RX_FULL]  = (rx_q.size() == FIFO_DEPTH);
			d[uart_axi_pkg::STAT_TX_EMPTY] = (tx_q.size() == 0);
			d[uart_axi_pkg::STAT_TX_FULL]  = (tx_q.size() == FIFO_DEPTH);
		end
		uart_axi_pkg::REG_RDATA: begin
			if (rx_q.size() > 0)
				d[7:0] = rx_q.pop_front();
			else
				ok = 1'b0; // nothing received yet
		end
		default: ok = 1'b0;
	endcase
	return d;
endfunction

function automatic logic model_write(input uart_axi_pkg::reg_sel_t sel,
		input uart_axi_pkg::data_t d, input uart_axi_pkg::strb_t s);
	if (sel == uart_axi_pkg::REG_CTRL) begin
		for (int i = 0; i < 4; i++) begin
			if (s[i])
				m_ctrl[8*i +: 8] = d[8*i +: 8];
		end
		return 1'b1;
	end
	if (tx_q.size() == FIFO_DEPTH)
		return 1'b0; // byte is lost
	tx_q.push_back(d[7:0]);
	return 1'b1;
endfunction

// one byte leaves the transmitter
function automatic uart_axi_pkg::byte_t model_tx_done();
	uart_axi_pkg::byte_t b;
	if (tx_q.size() == 0)
		stop_on_error("transmitter completed a byte while the reference queue was empty");
	b = tx_q.pop_front();
	if (tx_q.size() == 0)
		m_ctrl[uart_axi_pkg::CTRL_TX_EN_BIT] = 1'b0;
	return b;
endfunction

function automatic void model_rx_in(input uart_axi_pkg::byte_t b);
	if (m_ctrl[uart_axi_pkg::CTRL_RX_EN_BIT] && rx_q.size() < FIFO_DEPTH) begin
		rx_q.push_back(b);
		if (rx_q.size() == FIFO_DEPTH)
			m_ctrl[uart_axi_pkg::CTRL_RX_EN_BIT] = 1'b0;
	end
endfunction

task automatic check_data(input string what, input uart_axi_pkg::data_t got,
		input uart_axi_pkg::data_t exp);
	if (got !== exp)
		stop_on_error($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_byte(input string what, input uart_axi_pkg::byte_t got,
		input uart_axi_pkg::byte_t exp);
	if (got !== exp)
		stop_on_error($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_resp(input string what, input logic got, input logic exp);
	if (got !== exp)
		stop_on_error($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

// one falling edge of a bounded wait
task automatic tick_or_timeout(inout int n, input string what);
	@(negedge aclk);
	n++;
	if (n > WAIT_LIMIT)
		stop_on_error({"timed out waiting for ", what});
endtask

`endif

//--- sim/tb_uart_axi_regs.sv
`timescale 1ns/1ps

module tb_uart_axi_regs;

	localparam int FIFO_DEPTH = 32;

	logic                aclk = 1'b0;
	logic                aresetn; // active high
	uart_axi_pkg::addr_t araddr;
	logic                arvalid;
	logic                arready;
	logic                rready;
	logic                rvalid;
	uart_axi_pkg::data_t rdata;
	logic                rresp;
	uart_axi_pkg::addr_t awaddr;
	logic                awvalid;
	logic                awready;
	uart_axi_pkg::data_t wdata;
	uart_axi_pkg::strb_t wstrb;
	logic                wvalid;
	logic                wready;
	logic                bready;
	logic                bvalid;
	logic                bresp;
	logic                r_done;
	logic                t_done;
	uart_axi_pkg::byte_t rx_data;
	logic                rx_en;
	logic                tx_en;
	uart_axi_pkg::byte_t tx_data;
	logic [15:0]         baud_div;
	uart_axi_pkg::data_t exp_rdata[$];
	logic                exp_rresp[$];
	logic                exp_bresp[$];

	uart_axi_regs #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (
		.s_axi_aclk_i(aclk), .s_axi_aresetn_i(aresetn),
		.s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid), .s_axi_arready_o(arready),
		.s_axi_rready_i(rready), .s_axi_rvalid_o(rvalid), .s_axi_rdata_o(rdata),
		.s_axi_rresp_o(rresp),
		.s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
		.s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wvalid_i(wvalid),
		.s_axi_wready_o(wready),
		.s_axi_bready_i(bready), .s_axi_bvalid_o(bvalid), .s_axi_bresp_o(bresp),
		.r_done_i(r_done), .t_done_i(t_done), .rx_i(rx_data),
		.rx_en_o(rx_en), .tx_en_o(tx_en), .tx_o(tx_data), .baud_div_o(baud_div)
	);

	always #5 aclk = ~aclk;

	function void stop_on_error(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endfunction

	`include "tb_uart_checks.svh"

	function automatic uart_axi_pkg::addr_t addr_of(input uart_axi_pkg::reg_sel_t sel);
		return uart_axi_pkg::UART_BASE_ADDR | uart_axi_pkg::addr_t'({sel, 2'b00});
	endfunction

	function int hold_span();
		logic [31:0] r;
		r = next_rand();
		return int'(r[2:0]);
	endfunction

	task automatic bus_read(input uart_axi_pkg::reg_sel_t sel, input int hold);
		int   n;
		logic ok;
		exp_rdata.push_back(model_read(sel, ok));
		exp_rresp.push_back(ok);
		araddr  = addr_of(sel);
		arvalid = 1'b1;
		n = 0;
		while (!arready)
			tick_or_timeout(n, "arready");
		arvalid = 1'b0;
		repeat (hold) begin
			@(negedge aclk);
			check_resp("rvalid while rready low", rvalid, 1'b0);
		end
		rready = 1'b1;
		n = 0;
		while (!rvalid)
			tick_or_timeout(n, "rvalid");
		rready = 1'b0;
	endtask

	task automatic bus_write(input uart_axi_pkg::reg_sel_t sel, input uart_axi_pkg::data_t d,
			input uart_axi_pkg::strb_t s, input int hold);
		int n;
		exp_bresp.push_back(model_write(sel, d, s));
		awaddr  = addr_of(sel);
		awvalid = 1'b1;
		wdata   = d;
		wstrb   = s;
		wvalid  = 1'b1;
		n = 0;
		while (!awready)
			tick_or_timeout(n, "awready");
		check_resp("wready with awready", wready, 1'b1);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		repeat (hold) begin
			@(negedge aclk);
			check_resp("bvalid while bready low", bvalid, 1'b0);
		end
		bready = 1'b1;
		n = 0;
		while (!bvalid)
			tick_or_timeout(n, "bvalid");
		bready = 1'b0;
	endtask

	task automatic send_rx(input uart_axi_pkg::byte_t b);
		model_rx_in(b);
		rx_data = b;
		r_done  = 1'b1;
		@(negedge aclk);
		r_done = 1'b0;
		repeat (2) @(negedge aclk);
	endtask

	task automatic wait_tx_drain();
		int n;
		n = 0;
		while (tx_en)
			tick_or_timeout(n, "tx_en_o to clear after the queue drained");
	endtask

	// external transmitter finishing each byte after a random delay
	initial begin : tx_model
		logic [31:0]         r;
		uart_axi_pkg::byte_t exp_b;
		forever begin
			@(negedge aclk);
			if (tx_en) begin
				r = next_rand();
				repeat (2 + int'(r[1:0])) @(negedge aclk);
				if (tx_en) begin
					exp_b = model_tx_done();
					check_byte("tx_o", tx_data, exp_b);
					t_done = 1'b1;
					@(negedge aclk);
					t_done = 1'b0;
				end
			end
		end
	end

	always @(negedge aclk) begin : compare_resp
		uart_axi_pkg::data_t ed;
		logic                er;
		if (rvalid) begin
			if (exp_rdata.size() == 0)
				stop_on_error("a read response arrived with no read pending");
			ed = exp_rdata.pop_front();
			er = exp_rresp.pop_front();
			check_data("read data", rdata, ed);
			check_resp("read response", rresp, er);
		end
		if (bvalid) begin
			if (exp_bresp.size() == 0)
				stop_on_error("a write response arrived with no write pending");
			er = exp_bresp.pop_front();
			check_resp("write response", bresp, er);
		end
	end

	initial begin : main_seq
		logic [31:0] rnd;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		r_done  = 1'b0;
		t_done  = 1'b0;
		rx_data = '0;
		aresetn = 1'b1;
		repeat (10) @(negedge aclk);
		aresetn = 1'b0;

		bus_read(uart_axi_pkg::REG_CTRL, 0);
		bus_read(uart_axi_pkg::REG_STATUS, 0);
		check_resp("tx_en_o after reset", tx_en, 1'b0);
		check_resp("rx_en_o after reset", rx_en, 1'b0);

		// strobe merging with the enable bits kept off
		for (int i = 0; i < 8; i++) begin
			rnd = next_rand();
			bus_write(uart_axi_pkg::REG_CTRL, next_rand() & 32'hFFFF_FFFC, rnd[3:0], hold_span());
			bus_read(uart_axi_pkg::REG_CTRL, hold_span());
			check_data("baud_div_o", uart_axi_pkg::data_t'(baud_div),
				uart_axi_pkg::data_t'(m_ctrl[31:16]));
		end

		for (int i = 0; i < 5; i++) begin
			bus_write(uart_axi_pkg::REG_WDATA, next_rand(), 4'hF, hold_span());
			bus_read(uart_axi_pkg::REG_STATUS, hold_span());
		end
		bus_write(uart_axi_pkg::REG_CTRL, 32'h1, 4'h1, 0);
		wait_tx_drain();
		bus_read(uart_axi_pkg::REG_CTRL, 0);
		bus_read(uart_axi_pkg::REG_STATUS, 0);

		// one byte past full is refused
		for (int i = 0; i < FIFO_DEPTH + 1; i++)
			bus_write(uart_axi_pkg::REG_WDATA, next_rand(), 4'hF, 0);
		bus_read(uart_axi_pkg::REG_STATUS, 0);
		bus_write(uart_axi_pkg::REG_CTRL, 32'h1, 4'h1, 0);
		wait_tx_drain();
		bus_read(uart_axi_pkg::REG_CTRL, 0);
		bus_read(uart_axi_pkg::REG_STATUS, 0);

		bus_write(uart_axi_pkg::REG_CTRL, 32'h2, 4'h1, 0);
		for (int i = 0; i < 4; i++)
			send_rx(next_rand());
		for (int i = 0; i < 4; i++)
			bus_read(uart_axi_pkg::REG_RDATA, hold_span());
		bus_read(uart_axi_pkg::REG_RDATA, 0); // empty queue
		for (int i = 0; i < FIFO_DEPTH; i++)
			send_rx(next_rand());
		bus_read(uart_axi_pkg::REG_STATUS, 0);
		check_resp("rx_en_o after queue filled", rx_en, 1'b0);
		bus_read(uart_axi_pkg::REG_CTRL, 0);
		send_rx(8'hA5);
		send_rx(8'h5A);
		for (int i = 0; i < FIFO_DEPTH; i++)
			bus_read(uart_axi_pkg::REG_RDATA, hold_span());
		bus_read(uart_axi_pkg::REG_STATUS, 0);

		// long back-pressure spans
		for (int i = 0; i < 10; i++) begin
			rnd = next_rand();
			bus_write(uart_axi_pkg::REG_CTRL, rnd & 32'hFFFF_FFFC, 4'hF, int'(rnd[11:8]));
			bus_read(uart_axi_pkg::REG_CTRL, int'(rnd[15:12]));
			bus_read(uart_axi_pkg::REG_STATUS, int'(rnd[19:16]));
		end

		repeat (3) @(negedge aclk);
		if (exp_rdata.size() != 0 || exp_bresp.size() != 0) begin
			stop_on_error("responses were still missing at the end of the run");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

//--- uart_axi_regs.f
+incdir+include
source/uart_axi_pkg.sv
source/uart_axi_fsm.sv
source/uart_reg_file.sv
source/uart_byte_fifo.sv
source/uart_tx_feeder.sv
source/uart_axi_regs.sv
sim/tb_uart_axi_regs.sv

//--- run_sim.sh
#!/bin/sh
# build and run the UART register testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f uart_axi_regs.f --top-module tb_uart_axi_regs \
	-Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Everything OK" sim.log; then
	exit 0
fi
echo "simulation did not pass, exit status $run_status"
exit 1
